//--- hdl/classifierPkg.sv
package classifierPkg;

    // Format codes 6 and 7 are left unused.
    typedef enum logic [2:0] {
        FmtUnknown = 3'd0,
        FmtCompute = 3'd1,
        FmtMemory  = 3'd2,
        FmtControl = 3'd3,
        FmtMixed   = 3'd4,
        FmtIdle    = 3'd5
    } formatT;

    // Opcode categories and their index in the hit vector.
    localparam int NumCategories = 3;
    localparam int CatCompute    = 0;
    localparam int CatMemory     = 1;
    localparam int CatControl    = 2;

    localparam int CountWidth    = 8;  // Windowed counters and tolls.
    localparam int ConfWidth     = 4;
    localparam int DecCountWidth = 16;
    localparam int TimerWidth    = 4;
    localparam int RateWidth     = 8;

    localparam int DecideEvery = 8;  // Cycles between decisions.
    localparam int ClearEvery  = 16; // Cycles per counting window.

    localparam logic [CountWidth-1:0] CountMax = '1;
    localparam logic [ConfWidth-1:0]  ConfMax  = '1;

    // RV32 major opcodes.
    localparam logic [6:0] OpAluReg = 7'b0110011;
    localparam logic [6:0] OpAluImm = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;

    // Toll scaling for full and sparse windows.
    localparam logic [CountWidth-1:0] TollFullScale = 200;
    localparam logic [CountWidth-1:0] TollLowScale  = 100;

    localparam logic [CountWidth-1:0] DominantThreshold = 150;
    localparam logic [CountWidth-1:0] DominantMargin    = 80;
    localparam logic [CountWidth-1:0] MixedFloor        = 50;
    localparam logic [CountWidth-1:0] MixedCtrlFloor    = 40;
    localparam logic [CountWidth-1:0] MixedBalance      = 40;
    localparam logic [CountWidth-1:0] MixedCtrlBalance  = 50;

    localparam logic [CountWidth-1:0] IdleLimit       = 25;
    localparam logic [CountWidth-1:0] MinActiveDecide = 2;
    localparam logic [CountWidth-1:0] MinActiveValid  = 4;

    localparam logic [ConfWidth-1:0] ConfThreshold = 4;
    localparam logic [ConfWidth-1:0] ConfDominant  = 7;
    localparam logic [ConfWidth-1:0] ConfMixed     = 6;
    localparam logic [ConfWidth-1:0] ConfIdle      = 8;
    localparam logic [ConfWidth-1:0] ConfFloor     = 4;
    localparam logic [ConfWidth-1:0] StableBoost   = 2;

    localparam logic [RateWidth-1:0] RateSlow = 8;
    localparam logic [RateWidth-1:0] RateMid  = 16;
    localparam logic [RateWidth-1:0] RateFast = 32;

    // Stability bounds.
    localparam logic [CountWidth-1:0] StableHigh  = 15;
    localparam logic [CountWidth-1:0] StableMid   = 6;
    localparam logic [CountWidth-1:0] StableFloor = 2; // Boost starts above this.

endpackage

//--- hdl/mixIf.sv
interface mixIf;

    import classifierPkg::*;

    logic [NumCategories-1:0] hit;         // One category hit per valid opcode.
    logic [CountWidth-1:0]    activeCount; // Valid instructions this window.
    logic [CountWidth-1:0]    idleCount;   // Consecutive empty cycles.
    logic                     decide;      // Decision strobe.
    logic                     windowClear; // Window restart strobe.

    modport source (
        output hit,
        output activeCount,
        output idleCount,
        output decide,
        output windowClear
    );

    // Per-category counters.
    modport share (
        input hit,
        input activeCount,
        input windowClear
    );

    modport decision (
        input activeCount,
        input idleCount,
        input decide
    );

endinterface

//--- hdl/opcodeDecoder.sv
module opcodeDecoder (
    input  logic       clk,
    input  logic       reset,
    input  logic       instructionValid,
    input  logic [6:0] opcode,
    mixIf.source       mix
);

    import classifierPkg::*;

    localparam int DecideBits = $clog2(DecideEvery);
    localparam int ClearBits  = $clog2(ClearEvery);

    logic [TimerWidth-1:0]    timer;
    logic [NumCategories-1:0] hit;
    logic [CountWidth-1:0]    activeCount;
    logic [CountWidth-1:0]    idleCount;

    // Epoch timer, zero in the first cycle out of reset.
    always_ff @(posedge clk) begin
        if (!reset) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    assign mix.decide      = (timer[DecideBits-1:0] == '0);
    assign mix.windowClear = (timer[ClearBits-1:0] == '0);

    // Opcode categorization.
    always_comb begin
        hit = '0;
        if (instructionValid) begin
            case (opcode)
                OpAluReg, OpAluImm:      hit[CatCompute] = 1'b1;
                OpLoad, OpStore:         hit[CatMemory]  = 1'b1;
                OpBranch, OpJal, OpJalr: hit[CatControl] = 1'b1;
                default:                 hit = '0; // Activity only.
            endcase
        end
    end

    assign mix.hit = hit;

    // Active count restarts with each window.
    always_ff @(posedge clk) begin
        if (!reset) begin
            activeCount <= '0;
        end else if (mix.windowClear) begin
            activeCount <= '0; // Hit at this edge is dropped.
        end else if (instructionValid && activeCount != CountMax) begin
            activeCount <= activeCount + 1'b1;
        end
    end

    // Idle run length, independent of the window.
    always_ff @(posedge clk) begin
        if (!reset) begin
            idleCount <= '0;
        end else if (instructionValid) begin
            idleCount <= '0;
        end else if (idleCount != CountMax) begin
            idleCount <= idleCount + 1'b1;
        end
    end

    assign mix.activeCount = activeCount;
    assign mix.idleCount   = idleCount;

endmodule

//--- hdl/opcodeShare.sv
module opcodeShare (
    input  logic                               clk,
    input  logic                               reset,
    mixIf.share                                mix,
    input  logic                               category,
    output logic [classifierPkg::CountWidth-1:0] toll
);

    import classifierPkg::*;

    logic [CountWidth-1:0]   count;
    logic [2*CountWidth-1:0] product;
    logic [2*CountWidth-1:0] scaled;

    // Windowed hit counter, saturating.
    always_ff @(posedge clk) begin
        if (!reset) begin
            count <= '0;
        end else if (mix.windowClear) begin
            count <= '0;
        end else if (category && count != CountMax) begin
            count <= count + 1'b1;
        end
    end

    // Share of the window, scaled and clipped to 8 bits.
    always_comb begin
        product = '0;
        scaled  = '0;
        if (mix.activeCount >= MinActiveValid) begin
            product = (2*CountWidth)'(count) * (2*CountWidth)'(TollFullScale);
            scaled  = product / (2*CountWidth)'(mix.activeCount);
        end else if (mix.activeCount != '0) begin
            // Too few instructions for a ratio.
            product = (2*CountWidth)'(count) * (2*CountWidth)'(TollLowScale);
            scaled  = product;
        end
        if (scaled > (2*CountWidth)'(CountMax)) begin
            toll = CountMax;
        end else begin
            toll = scaled[CountWidth-1:0];
        end
    end

endmodule

//--- hdl/workloadDecision.sv
module workloadDecision (
    input  logic                                  clk,
    input  logic                                  reset,
    mixIf.decision                                mix,
    input  logic [classifierPkg::CountWidth-1:0]  toll [classifierPkg::NumCategories],
    output classifierPkg::formatT                 workloadFormat,
    output logic [classifierPkg::ConfWidth-1:0]   workloadConfidence,
    output logic [classifierPkg::DecCountWidth-1:0] classificationCount,
    output logic [classifierPkg::RateWidth-1:0]   adaptationRate,
    output logic                                  classificationValid
);

    import classifierPkg::*;

    formatT                prevFormat;
    formatT                ruleFormat;
    logic [ConfWidth-1:0]  ruleConf;
    logic [ConfWidth-1:0]  nextConf;
    logic [CountWidth-1:0] stability;
    logic [CountWidth-1:0] computeToll;
    logic [CountWidth-1:0] memToll;
    logic [CountWidth-1:0] controlToll;
    logic                  isMixed;

    // True when a clearly leads both b and c.
    function automatic logic dominates(input logic [CountWidth-1:0] a,
                                       input logic [CountWidth-1:0] b,
                                       input logic [CountWidth-1:0] c);
        logic [CountWidth:0] boundB;
        logic [CountWidth:0] boundC;
        boundB = {1'b0, b} + {1'b0, DominantMargin};
        boundC = {1'b0, c} + {1'b0, DominantMargin};
        return (a > DominantThreshold) && ({1'b0, a} > boundB) && ({1'b0, a} > boundC);
    endfunction

    function automatic logic [CountWidth-1:0] absDiff(input logic [CountWidth-1:0] a,
                                                      input logic [CountWidth-1:0] b);
        return (a > b) ? a - b : b - a;
    endfunction

    assign computeToll = toll[CatCompute];
    assign memToll     = toll[CatMemory];
    assign controlToll = toll[CatControl];

    // Any two active categories close to each other.
    assign isMixed =
        (computeToll > MixedFloor && memToll > MixedFloor &&
         absDiff(computeToll, memToll) < MixedBalance) ||
        (computeToll > MixedFloor && controlToll > MixedCtrlFloor &&
         absDiff(computeToll, controlToll) < MixedCtrlBalance) ||
        (memToll > MixedFloor && controlToll > MixedCtrlFloor &&
         absDiff(memToll, controlToll) < MixedCtrlBalance);

    // Rule chain, first match wins.
    always_comb begin
        ruleFormat = FmtUnknown;
        ruleConf   = ConfFloor;
        if (classificationCount == '0) begin
            ruleFormat = FmtUnknown; // First decision has no history.
        end else if (mix.idleCount > IdleLimit) begin
            ruleFormat = FmtIdle;
            ruleConf   = ConfIdle;
        end else if (mix.activeCount < MinActiveDecide) begin
            ruleFormat = FmtUnknown;
        end else if (dominates(computeToll, memToll, controlToll)) begin
            ruleFormat = FmtCompute;
            ruleConf   = ConfDominant;
        end else if (dominates(memToll, computeToll, controlToll)) begin
            ruleFormat = FmtMemory;
            ruleConf   = ConfDominant;
        end else if (dominates(controlToll, computeToll, memToll)) begin
            ruleFormat = FmtControl;
            ruleConf   = ConfDominant;
        end else if (isMixed) begin
            ruleFormat = FmtMixed;
            ruleConf   = ConfMixed;
        end else if (workloadFormat != FmtUnknown) begin
            // Hold the last format with decaying confidence.
            ruleFormat = workloadFormat;
            ruleConf   = (workloadConfidence > ConfFloor) ? workloadConfidence - 1'b1 : ConfFloor;
        end
    end

    // A settled format overrides the rule confidence.
    always_comb begin
        nextConf = ruleConf;
        if (workloadFormat == prevFormat && stability > StableFloor) begin
            if (workloadConfidence > ConfMax - StableBoost) begin
                nextConf = ConfMax;
            end else begin
                nextConf = workloadConfidence + StableBoost;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            workloadFormat      <= FmtUnknown;
            prevFormat          <= FmtUnknown;
            workloadConfidence  <= '0;
            classificationCount <= '0;
            stability           <= '0;
        end else if (mix.decide) begin
            workloadFormat      <= ruleFormat;
            workloadConfidence  <= nextConf;
            prevFormat          <= workloadFormat;
            classificationCount <= classificationCount + 1'b1;
            if (workloadFormat != prevFormat) begin
                stability <= '0;
            end else if (stability != CountMax) begin
                stability <= stability + 1'b1;
            end
        end
    end

    // Slower adaptation once the format has settled.
    always_comb begin
        if (stability > StableHigh) begin
            adaptationRate = RateSlow;
        end else if (stability > StableMid) begin
            adaptationRate = RateMid;
        end else begin
            adaptationRate = RateFast;
        end
    end

    assign classificationValid = (workloadConfidence >= ConfThreshold) &&
                                 (mix.activeCount >= MinActiveValid) &&
                                 (classificationCount != '0);

endmodule

//--- hdl/workloadClassifier.sv
module workloadClassifier (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    instructionValid,
    input  logic [6:0]                              opcode,
    output logic [classifierPkg::CountWidth-1:0]    computeToll,
    output logic [classifierPkg::CountWidth-1:0]    memToll,
    output logic [classifierPkg::CountWidth-1:0]    controlToll,
    output classifierPkg::formatT                   workloadFormat,
    output logic [classifierPkg::ConfWidth-1:0]     workloadConfidence,
    output logic [classifierPkg::DecCountWidth-1:0] classificationCount,
    output logic [classifierPkg::RateWidth-1:0]     adaptationRate,
    output logic                                    classificationValid
);

    import classifierPkg::*;

    logic [CountWidth-1:0] tollArr [NumCategories];

    mixIf mix ();

    opcodeDecoder decoderInst (
        .clk              (clk),
        .reset            (reset),
        .instructionValid (instructionValid),
        .opcode           (opcode),
        .mix              (mix.source)
    );

    // One share counter per category.
    for (genvar i = 0; i < NumCategories; i++) begin : genShare
        opcodeShare shareInst (
            .clk      (clk),
            .reset    (reset),
            .mix      (mix.share),
            .category (mix.hit[i]),
            .toll     (tollArr[i])
        );
    end

    workloadDecision decisionInst (
        .clk                 (clk),
        .reset               (reset),
        .mix                 (mix.decision),
        .toll                (tollArr),
        .workloadFormat      (workloadFormat),
        .workloadConfidence  (workloadConfidence),
        .classificationCount (classificationCount),
        .adaptationRate      (adaptationRate),
        .classificationValid (classificationValid)
    );

    assign computeToll = tollArr[CatCompute];
    assign memToll     = tollArr[CatMemory];
    assign controlToll = tollArr[CatControl];

endmodule

//--- verif/tbWorkloadClassifier.sv
module tbWorkloadClassifier;

    import classifierPkg::*;

    localparam int ClkPeriod    = 40;
    localparam int DriveDelay   = 5;
    localparam int ResetCycles  = 16;
    localparam int PhaseCycles  = 96;
    localparam int CheckCycles  = 32; // Checked tail of each phase.
    localparam int NumPhases    = 8;
    localparam int MarginCycles = 100;
    localparam int IdleAfter    = 16; // Idle phase stops issuing here.
    localparam int WatchdogTime =
        (NumPhases * (PhaseCycles + ResetCycles) + MarginCycles) * ClkPeriod;

    // Stimulus patterns.
    localparam int PatRandom  = 0;
    localparam int PatCompute = 1;
    localparam int PatMemory  = 2;
    localparam int PatControl = 3;
    localparam int PatMixed   = 4;
    localparam int PatIdle    = 5;
    localparam int PatSteady  = 6;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     instructionValid;
    logic [6:0]               opcode;
    logic [CountWidth-1:0]    computeToll;
    logic [CountWidth-1:0]    memToll;
    logic [CountWidth-1:0]    controlToll;
    formatT                   workloadFormat;
    logic [ConfWidth-1:0]     workloadConfidence;
    logic [DecCountWidth-1:0] classificationCount;
    logic [RateWidth-1:0]     adaptationRate;
    logic                     classificationValid;

    int     seed = 32'h125b_1cbe;
    string  testName;
    int     pattern;
    int     phaseLength;
    int     phaseCycle;
    bit     inPhase;
    formatT expectFormat;
    bit     confTop;
    int     errors = 0;
    int     testsRun;
    int     testsFailed;

    // Reference model of the counts since the last window clear.
    int                    modelTimer;
    int                    modelActive;
    int                    modelCount [NumCategories];
    int                    modelDecisions;
    int                    modelCat;
    logic [CountWidth-1:0] expCompute;
    logic [CountWidth-1:0] expMemory;
    logic [CountWidth-1:0] expControl;

    workloadClassifier dut_i (
        .clk                 (clk),
        .reset               (reset),
        .instructionValid    (instructionValid),
        .opcode              (opcode),
        .computeToll         (computeToll),
        .memToll             (memToll),
        .controlToll         (controlToll),
        .workloadFormat      (workloadFormat),
        .workloadConfidence  (workloadConfidence),
        .classificationCount (classificationCount),
        .adaptationRate      (adaptationRate),
        .classificationValid (classificationValid)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic int categoryOf(input logic [6:0] op);
        case (op)
            OpAluReg, OpAluImm:      return CatCompute;
            OpLoad, OpStore:         return CatMemory;
            OpBranch, OpJal, OpJalr: return CatControl;
            default:                 return NumCategories; // No category.
        endcase
    endfunction

    // Expected toll from a category count and the active count.
    function automatic logic [CountWidth-1:0] expectedToll(input int count, input int active);
        int share;
        if (active >= 4) begin
            share = count * 200 / active;
        end else if (active >= 1) begin
            share = count * 100;
        end else begin
            share = 0;
        end
        if (share > 255) begin
            share = 255;
        end
        return CountWidth'(share);
    endfunction

    function automatic logic [6:0] pickOpcode(input int idx);
        case (idx)
            0:       return OpAluReg;
            1:       return OpAluImm;
            2:       return OpLoad;
            3:       return OpStore;
            4:       return OpBranch;
            5:       return OpJal;
            6:       return OpJalr;
            7:       return 7'b0110111; // LUI only counts as activity.
            default: return 7'b1110011; // SYSTEM only counts as activity.
        endcase
    endfunction

    assign expCompute = expectedToll(modelCount[CatCompute], modelActive);
    assign expMemory  = expectedToll(modelCount[CatMemory], modelActive);
    assign expControl = expectedToll(modelCount[CatControl], modelActive);

    always @(posedge clk) begin
        if (!reset) begin
            modelTimer     <= 0;
            modelActive    <= 0;
            modelDecisions <= 0;
            for (int c = 0; c < NumCategories; c++) begin
                modelCount[c] <= 0;
            end
        end else begin
            modelTimer <= (modelTimer + 1) % (1 << TimerWidth);
            if (modelTimer % DecideEvery == 0) begin
                modelDecisions <= modelDecisions + 1;
            end
            if (modelTimer % ClearEvery == 0) begin
                modelActive <= 0; // Hit at a clear edge is lost.
                for (int c = 0; c < NumCategories; c++) begin
                    modelCount[c] <= 0;
                end
            end else if (instructionValid) begin
                modelCat = categoryOf(opcode);
                if (modelActive < 255) begin
                    modelActive <= modelActive + 1;
                end
                if (modelCat < NumCategories) begin
                    if (modelCount[modelCat] < 255) begin
                        modelCount[modelCat] <= modelCount[modelCat] + 1;
                    end
                end
            end
        end
    end

    task automatic valueError(input string field, input int expected, input int actual);
        errors++;
        $display("** Error: %s: %s expected %0d, actual %0d", testName, field, expected, actual);
    endtask

    // Outputs are sampled mid-cycle, away from both edges.
    always @(negedge clk) begin
        if (inPhase && reset) begin
            if (phaseCycle == 0) begin
                confTop = 1'b0;
            end
            assert (computeToll == expCompute)
                else valueError("computeToll", int'(expCompute), int'(computeToll));
            assert (memToll == expMemory)
                else valueError("memToll", int'(expMemory), int'(memToll));
            assert (controlToll == expControl)
                else valueError("controlToll", int'(expControl), int'(controlToll));
            assert (int'(classificationCount) == modelDecisions)
                else valueError("classificationCount", modelDecisions,
                                int'(classificationCount));
            if (pattern == PatSteady && confTop) begin
                assert (workloadConfidence == ConfMax)
                    else valueError("confidence hold", int'(ConfMax), int'(workloadConfidence));
            end
            if (workloadConfidence == ConfMax) begin
                confTop = 1'b1;
            end
            if (pattern != PatRandom && phaseCycle >= phaseLength - CheckCycles) begin
                assert (workloadFormat == expectFormat)
                    else valueError("workloadFormat", int'(expectFormat), int'(workloadFormat));
                if (pattern == PatIdle) begin
                    assert (!classificationValid)
                        else valueError("classificationValid", 0, int'(classificationValid));
                end else if (pattern != PatMixed && modelTimer % DecideEvery == 0) begin
                    assert (classificationValid)
                        else valueError("classificationValid", 1, int'(classificationValid));
                end
                if (pattern == PatSteady) begin
                    assert (workloadConfidence == ConfMax)
                        else valueError("workloadConfidence", int'(ConfMax),
                                        int'(workloadConfidence));
                    assert (adaptationRate == RateSlow)
                        else valueError("adaptationRate", int'(RateSlow), int'(adaptationRate));
                end
            end
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #(DriveDelay);
    endtask

    task automatic applyReset();
        reset            = 1'b0;
        instructionValid = 1'b0;
        opcode           = '0;
        repeat (ResetCycles) nextCycle();
        reset = 1'b1;
    endtask

    task automatic driveCycle(input int k);
        int r;
        instructionValid = 1'b1;
        opcode           = OpAluReg;
        case (pattern)
            PatRandom: begin
                r                = $random(seed);
                instructionValid = r[0];
                opcode           = pickOpcode(int'(r[8:1]) % 9);
            end
            PatCompute: opcode = k[0] ? OpAluImm : OpAluReg;
            PatMemory:  opcode = k[0] ? OpStore : OpLoad;
            PatControl: opcode = pickOpcode(4 + k % 3);
            PatMixed:   opcode = k[0] ? OpLoad : OpAluReg;
            PatIdle:    instructionValid = (k < IdleAfter);
            default:    opcode = OpAluReg; // Steady compute stream.
        endcase
    endtask

    task automatic runPhase(input string name, input int pat, input int cycles,
                            input formatT fmt);
        int errorsBefore;
        errorsBefore = errors;
        testName     = name;
        pattern      = pat;
        phaseLength  = cycles;
        expectFormat = fmt;
        applyReset();
        inPhase = 1'b1;
        for (int k = 0; k < cycles; k++) begin
            phaseCycle = k;
            driveCycle(k);
            nextCycle();
        end
        inPhase = 1'b0;
        testsRun++;
        if (errors != errorsBefore) begin
            testsFailed++;
            $display("%-8s failed, %0d errors", name, errors - errorsBefore);
        end else begin
            $display("%-8s ok", name);
        end
    endtask

    initial begin
        reset            = 1'b0;
        instructionValid = 1'b0;
        opcode           = '0;
        testsRun         = 0;
        testsFailed      = 0;
        inPhase          = 1'b0;
        phaseCycle       = 0;
        phaseLength      = PhaseCycles;
        pattern          = PatRandom;
        expectFormat     = FmtUnknown;
        testName         = "none";
        runPhase("random", PatRandom, PhaseCycles, FmtUnknown);
        runPhase("compute", PatCompute, PhaseCycles, FmtCompute);
        runPhase("memory", PatMemory, PhaseCycles, FmtMemory);
        runPhase("control", PatControl, PhaseCycles, FmtControl);
        runPhase("mixed", PatMixed, PhaseCycles, FmtMixed);
        runPhase("idle", PatIdle, PhaseCycles, FmtIdle);
        runPhase("steady", PatSteady, 2 * PhaseCycles, FmtCompute); // Two phases long.
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WatchdogTime);
        $display("Watchdog expired after %0d time units, the run did not finish", WatchdogTime);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- workloadClassifier.f
hdl/classifierPkg.sv
hdl/mixIf.sv
hdl/opcodeDecoder.sv
hdl/opcodeShare.sv
hdl/workloadDecision.sv
hdl/workloadClassifier.sv
verif/tbWorkloadClassifier.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

TOP=tbWorkloadClassifier
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module "$TOP" \
    -f workloadClassifier.f \
    -o "sim_$TOP"

./obj_dir/"sim_$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
echo "Simulation finished without failures"
